/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_dsp_slice
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
verilog/dsp_pkg.sv
verilog/dsp_lane_adder.sv
verilog/dsp_partial_mult.sv
verilog/dsp_simd_adder.sv
verilog/dsp_op_decode.sv
verilog/dsp_wb_regs.sv
verilog/dsp_result_reg.sv
verilog/dsp_slice_top.sv
verification/tb_dsp_slice.sv

/* verification/tb_dsp_slice.sv */
`timescale 1ns/1ps

module tb_dsp_slice
	import dsp_pkg::*;
();

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [2:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	logic [15:0] lfsr = 16'd64;
	logic [a_width-1:0] cur_a;
	logic [b_width-1:0] cur_b;
	logic [p_width-1:0] cur_c;
	logic [p_width-1:0] model_p = '0; // Running P, also the accumulator
	logic model_cout = 1'b0;
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int test_errors = 0;

	dsp_slice_top dut (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [47:0] random_bits(input int count);
		logic [47:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			value = {value[46:0], fb};
		end
		return value;
	endfunction

	function automatic logic [31:0] ctrl_word(input opcode_e op, input simd_mode_e mode,
			input logic cin);
		return {27'b0, cin, mode, op};
	endfunction

	task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int cycles;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		cycles = 0;
		do begin
			@(posedge clk);
			#2;
			cycles++;
		end while (!wb_ack && cycles < 50);
		if (!wb_ack) begin
			$display("Timeout: address %0d was never acknowledged at %0t", adr, $time);
			error_count++;
		end
		rdata = wb_dat_r; // Registered on the same edge as the ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_transfer(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
		wb_transfer(1'b0, adr, 32'd0, data);
	endtask

	task automatic load_operands(input logic [47:0] a_in, input logic [47:0] b_in,
			input logic [47:0] c_in);
		cur_a = a_in[a_width-1:0];
		cur_b = b_in[b_width-1:0];
		cur_c = c_in;
		wb_write(addr_a, 32'(cur_a));
		wb_write(addr_b, 32'(cur_b));
		wb_write(addr_c_lo, cur_c[31:0]);
		wb_write(addr_c_hi, 32'(cur_c[47:32]));
	endtask

	// Polls status until the slice goes idle, then fetches the low word
	task automatic read_result(output logic [p_width-1:0] p, output logic cout);
		logic [31:0] hi;
		logic [31:0] lo;
		int polls;
		polls = 0;
		do begin
			wb_read(addr_p_hi, hi);
			polls++;
		end while (hi[31] && polls < 20);
		if (hi[31]) begin
			$display("Timeout: busy never cleared at %0t", $time);
			error_count++;
		end
		wb_read(addr_p_lo, lo);
		p = {hi[15:0], lo};
		cout = hi[16];
	endtask

	task automatic predict_result(input opcode_e op, input simd_mode_e mode, input logic cin);
		simd_mode_e eff;
		logic [49:0] w;
		logic [49:0] x;
		logic [49:0] y;
		logic [49:0] mask;
		logic [49:0] s;
		logic [49:0] result;
		int g;
		if (op == op_mul_add || op == op_mul_acc)
			eff = mode_27x18;
		else
			eff = (mode == mode_27x18) ? mode_48 : mode;
		g = (eff == mode_24) ? 24 : (eff == mode_12) ? 12 : p_width;
		w = (op == op_mul_acc || op == op_acc) ? 50'(model_p) : 50'(cur_c);
		case (op)
			op_add: begin
				x = 50'({cur_a, cur_b});
				y = '0;
			end
			op_acc: begin
				x = 50'(cur_c);
				y = '0;
			end
			default: begin
				x = 50'(cur_a) * 50'(cur_b);
				y = '0;
			end
		endcase
		mask = (50'd1 << g) - 50'd1;
		result = '0;
		for (int k = 0; k < p_width / g; k++) begin
			s = ((w >> (k * g)) & mask) + ((x >> (k * g)) & mask) + ((y >> (k * g)) & mask);
			if (k == 0 && g == p_width)
				s = s + 50'(cin);
			result = result | ((s & mask) << (k * g));
			model_cout = s[g]; // The last group is the top one
		end
		model_p = result[p_width-1:0];
	endtask

	task automatic compare_p(input logic [p_width-1:0] got, input logic [p_width-1:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: p got %h expected %h", $time, got, expected);
			error_count++;
		end
	endtask

	task automatic compare_cout(input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: cout got %b expected %b", $time, got, expected);
			error_count++;
		end
	endtask

	task automatic run_op(input opcode_e op, input simd_mode_e mode, input logic cin);
		logic [p_width-1:0] got_p;
		logic got_cout;
		wb_write(addr_ctrl, ctrl_word(op, mode, cin));
		read_result(got_p, got_cout);
		predict_result(op, mode, cin);
		compare_p(got_p, model_p);
		compare_cout(got_cout, model_cout);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == test_errors) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, error_count - test_errors);
		end
		test_errors = error_count;
	endtask

	task automatic test_reset_state();
		logic [31:0] lo;
		logic [31:0] hi;
		wb_read(addr_p_lo, lo);
		wb_read(addr_p_hi, hi);
		compare_p({hi[15:0], lo}, '0);
		compare_cout(hi[16], 1'b0);
		if (hi != 32'd0) begin
			$display("P_HI has stray status bits set after reset: %h", hi);
			error_count++;
		end
		finish_test("reset state");
	endtask

	task automatic test_add_48();
		repeat (3) begin
			load_operands(random_bits(27), random_bits(18), random_bits(48));
			run_op(op_add, mode_48, 1'b1);
		end
		load_operands(48'h7ff_ffff, 48'h3_ffff, 48'hffff_ffff_ffff); // Carries out of bit 47
		run_op(op_add, mode_48, 1'b1);
		load_operands(random_bits(27), random_bits(18), random_bits(48));
		run_op(op_add, mode_27x18, 1'b0);
		finish_test("add mode_48");
	endtask

	task automatic test_simd_split();
		load_operands(48'h7ff_ffff, 48'h3_ffff, 48'hffff_ffff_ffff); // Every lane overflows
		run_op(op_add, mode_24, 1'b1);
		run_op(op_add, mode_12, 1'b1);
		run_op(op_acc, mode_24, 1'b1);
		run_op(op_acc, mode_12, 1'b1);
		load_operands(random_bits(27), random_bits(18), random_bits(48));
		run_op(op_add, mode_12, 1'b0);
		run_op(op_acc, mode_24, 1'b1);
		finish_test("add and acc split modes");
	endtask

	task automatic test_mul_add();
		repeat (3) begin
			load_operands(random_bits(27), random_bits(18), random_bits(48));
			run_op(op_mul_add, mode_48, random_bits(1) != 48'd0);
		end
		load_operands(48'h7ff_ffff, 48'h3_ffff, 48'hffff_ffff_ffff);
		run_op(op_mul_add, mode_12, 1'b1); // Mode must be overridden
		finish_test("mul_add");
	endtask

	task automatic test_mul_acc();
		repeat (3) begin
			load_operands(random_bits(27), random_bits(18), random_bits(48));
			run_op(op_mul_acc, mode_24, 1'b0);
		end
		finish_test("mul_acc chain");
	endtask

	task automatic test_back_to_back();
		logic [p_width-1:0] got_p;
		logic got_cout;
		time first_ack;
		load_operands(random_bits(27), random_bits(18), random_bits(48));
		wb_write(addr_ctrl, ctrl_word(op_add, mode_48, 1'b0));
		first_ack = $time;
		wb_write(addr_ctrl, ctrl_word(op_acc, mode_48, 1'b1)); // Acked only once the slice is idle
		// The first result lands two edges after its ack and busy holds until then
		if ($time - first_ack < 3 * 20) begin
			$display("Second CTRL write was acknowledged at %0t while the slice was busy",
				$time);
			error_count++;
		end
		read_result(got_p, got_cout);
		predict_result(op_add, mode_48, 1'b0);
		predict_result(op_acc, mode_48, 1'b1); // Second result builds on the first
		compare_p(got_p, model_p);
		compare_cout(got_cout, model_cout);
		finish_test("back-to-back CTRL");
	endtask

	initial begin
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 3'd0;
		wb_dat_w = 32'd0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset_state();
		test_add_48();
		test_simd_split();
		test_mul_add();
		test_mul_acc();
		test_back_to_back();
		$display("tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog/dsp_lane_adder.sv */
`timescale 1ns/1ps

module dsp_lane_adder #(
	parameter int width = 12
) (
	input logic [width-1:0] w,
	input logic [width-1:0] x,
	input logic [width-1:0] y,
	input logic [1:0] carry_in,
	output logic [width-1:0] sum,
	output logic [1:0] carry_out
);

	logic [width-1:0] cs_sum;
	logic [width-1:0] cs_major;
	logic [width:0] cs_carry;
	logic [width+1:0] total;

	// Full adder row, three operands down to two
	assign cs_sum = w ^ x ^ y;
	assign cs_major = (w & x) | (w & y) | (x & y);
	assign cs_carry = {cs_major, 1'b0};

	// Worst case is 3 * 2**width, which still fits in two extra bits
	assign total = {2'b00, cs_sum} + {1'b0, cs_carry} + {{width{1'b0}}, carry_in};

	assign sum = total[width-1:0];
	assign carry_out = total[width+1:width];

endmodule

/* verilog/dsp_op_decode.sv */
`timescale 1ns/1ps

module dsp_op_decode
	import dsp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input opcode_e opcode,
	input simd_mode_e mode,
	input logic cin,
	input logic [a_width-1:0] a,
	input logic [b_width-1:0] b,
	input logic [p_width-1:0] c,
	input logic [p_width-1:0] p,
	output logic valid,
	output logic [p_width-1:0] w,
	output logic [p_width-1:0] x,
	output logic [p_width-1:0] y,
	output simd_mode_e lane_mode,
	output logic carry_in
);

	logic [p_width-1:0] pp_lo;
	logic [p_width-1:0] pp_hi;
	logic [p_width-1:0] w_next;
	logic [p_width-1:0] x_next;
	logic [p_width-1:0] y_next;
	simd_mode_e add_mode;
	simd_mode_e mode_next;
	opcode_e op_q;

	dsp_partial_mult u_mult (
		.a(a),
		.b(b),
		.pp_lo(pp_lo),
		.pp_hi(pp_hi)
	);

	assign add_mode = (mode == mode_27x18) ? mode_48 : mode; // Multiplier mode is meaningless here

	always_comb begin
		w_next = c;
		x_next = pp_lo;
		y_next = pp_hi;
		mode_next = mode_27x18;
		case (opcode)
			op_mul_acc: w_next = p;
			op_add: begin
				x_next = {{(p_width - a_width - b_width){1'b0}}, a, b};
				y_next = '0;
				mode_next = add_mode;
			end
			op_acc: begin
				w_next = p;
				x_next = c;
				y_next = '0;
				mode_next = add_mode;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
			w <= '0;
			x <= '0;
			y <= '0;
			lane_mode <= mode_27x18;
			carry_in <= 1'b0;
			op_q <= op_mul_add;
		end else begin
			valid <= start;
			if (start) begin
				w <= w_next;
				x <= x_next;
				y <= y_next;
				lane_mode <= mode_next;
				carry_in <= cin;
				op_q <= opcode;
			end
		end
	end

	mul_full_width: assert property (@(posedge clk) disable iff (reset)
		(op_q inside {op_mul_add, op_mul_acc}) |-> (lane_mode == mode_27x18))
		else $error("Multiply issued with a split SIMD mode");

endmodule

/* verilog/dsp_partial_mult.sv */
`timescale 1ns/1ps

module dsp_partial_mult
	import dsp_pkg::*;
(
	input logic [a_width-1:0] a,
	input logic [b_width-1:0] b,
	output logic [p_width-1:0] pp_lo,
	output logic [p_width-1:0] pp_hi
);

	logic [b_width/2-1:0] b_lo;
	logic [b_width/2-1:0] b_hi;
	logic [a_width+b_width/2-1:0] prod_lo;
	logic [a_width+b_width/2-1:0] prod_hi;

	assign b_lo = b[b_width/2-1:0];
	assign b_hi = b[b_width-1:b_width/2];

	// Each row is a 27x9 product, the final add is left to the SIMD adder
	assign prod_lo = a * b_lo;
	assign prod_hi = a * b_hi;

	assign pp_lo = {{(p_width - a_width - b_width/2){1'b0}}, prod_lo};
	assign pp_hi = {{(p_width - a_width - b_width){1'b0}}, prod_hi, {(b_width/2){1'b0}}};

endmodule

/* verilog/dsp_pkg.sv */
package dsp_pkg;

	localparam int a_width = 27;
	localparam int b_width = 18;
	localparam int p_width = 48;

	localparam int lane_width = 12; // One SIMD lane of the adder
	localparam int lane_count = 4;

	// Word addresses of the Wishbone register map
	localparam logic [2:0] addr_a = 3'd0;
	localparam logic [2:0] addr_b = 3'd1;
	localparam logic [2:0] addr_c_lo = 3'd2;
	localparam logic [2:0] addr_c_hi = 3'd3;
	localparam logic [2:0] addr_ctrl = 3'd4;
	localparam logic [2:0] addr_p_lo = 3'd5; // Read only
	localparam logic [2:0] addr_p_hi = 3'd6; // Read only, carries status

	typedef enum logic [1:0] {
		op_mul_add = 2'b00,
		op_mul_acc = 2'b01,
		op_add = 2'b10,
		op_acc = 2'b11
	} opcode_e;

	typedef enum logic [1:0] {
		mode_27x18 = 2'b00, // Full width chain behind the multiplier
		mode_48 = 2'b01,
		mode_24 = 2'b10,
		mode_12 = 2'b11
	} simd_mode_e;

endpackage

/* verilog/dsp_result_reg.sv */
`timescale 1ns/1ps

module dsp_result_reg
	import dsp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid,
	input logic start,
	input logic [p_width-1:0] sum,
	input logic cout_in,
	output logic [p_width-1:0] p,
	output logic cout,
	output logic done,
	output logic busy
);

	always_ff @(posedge clk) begin
		if (reset) begin
			p <= '0;
			cout <= 1'b0;
			done <= 1'b0;
			busy <= 1'b0;
		end else begin
			done <= valid;
			if (valid) begin
				p <= sum; // Also the accumulator seen by decode
				cout <= cout_in;
			end
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	done_after_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(busy))
		else $error("Result completed without an operation in flight");

endmodule

/* verilog/dsp_simd_adder.sv */
`timescale 1ns/1ps

module dsp_simd_adder
	import dsp_pkg::*;
(
	input logic [p_width-1:0] w,
	input logic [p_width-1:0] x,
	input logic [p_width-1:0] y,
	input simd_mode_e lane_mode,
	input logic carry_in,
	output logic [p_width-1:0] sum,
	output logic cout
);

	logic chain_all;
	logic chain_pairs;

	assign chain_all = (lane_mode == mode_27x18) || (lane_mode == mode_48);
	assign chain_pairs = (lane_mode == mode_24);

	for (genvar i = 0; i < lane_count; i++) begin : g_lane
		logic [1:0] lane_cin;
		logic [1:0] lane_cout;

		if (i == 0) begin : g_first
			assign lane_cin = chain_all ? {1'b0, carry_in} : 2'b00; // cin only in full width
		end else begin : g_next
			// Odd lanes continue the lane below in mode_24
			assign lane_cin = (chain_all || (chain_pairs && (i % 2 == 1))) ?
				g_lane[i-1].lane_cout : 2'b00;
		end

		dsp_lane_adder #(
			.width(lane_width)
		) u_lane (
			.w(w[i*lane_width +: lane_width]),
			.x(x[i*lane_width +: lane_width]),
			.y(y[i*lane_width +: lane_width]),
			.carry_in(lane_cin),
			.sum(sum[i*lane_width +: lane_width]),
			.carry_out(lane_cout)
		);
	end

	assign cout = g_lane[lane_count-1].lane_cout[0];

endmodule

/* verilog/dsp_slice_top.sv */
`timescale 1ns/1ps

module dsp_slice_top
	import dsp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [2:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);

	logic start;
	opcode_e opcode;
	simd_mode_e mode;
	logic cin;
	logic [a_width-1:0] a;
	logic [b_width-1:0] b;
	logic [p_width-1:0] c;
	logic valid;
	logic [p_width-1:0] w;
	logic [p_width-1:0] x;
	logic [p_width-1:0] y;
	simd_mode_e lane_mode;
	logic carry_in;
	logic [p_width-1:0] sum;
	logic sum_cout;
	logic [p_width-1:0] p;
	logic cout;
	logic done;
	logic busy;

	dsp_wb_regs u_regs (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.busy(busy),
		.p(p),
		.cout(cout),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.start(start),
		.opcode(opcode),
		.mode(mode),
		.cin(cin),
		.a(a),
		.b(b),
		.c(c)
	);

	dsp_op_decode u_decode (
		.clk(clk),
		.reset(reset),
		.start(start),
		.opcode(opcode),
		.mode(mode),
		.cin(cin),
		.a(a),
		.b(b),
		.c(c),
		.p(p),
		.valid(valid),
		.w(w),
		.x(x),
		.y(y),
		.lane_mode(lane_mode),
		.carry_in(carry_in)
	);

	dsp_simd_adder u_adder (
		.w(w),
		.x(x),
		.y(y),
		.lane_mode(lane_mode),
		.carry_in(carry_in),
		.sum(sum),
		.cout(sum_cout)
	);

	dsp_result_reg u_result (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.start(start),
		.sum(sum),
		.cout_in(sum_cout),
		.p(p),
		.cout(cout),
		.done(done),
		.busy(busy)
	);

endmodule

/* verilog/dsp_wb_regs.sv */
`timescale 1ns/1ps

module dsp_wb_regs
	import dsp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [2:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic busy,
	input logic [p_width-1:0] p,
	input logic cout,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic start,
	output opcode_e opcode,
	output simd_mode_e mode,
	output logic cin,
	output logic [a_width-1:0] a,
	output logic [b_width-1:0] b,
	output logic [p_width-1:0] c
);

	logic bus_req;
	logic ctrl_wr;
	logic accept;
	logic [31:0] rd_data;

	assign bus_req = wb_cyc & wb_stb & ~wb_ack; // The ack cycle itself never re-arms
	assign ctrl_wr = wb_we & (wb_adr == addr_ctrl);
	assign accept = bus_req & ~(ctrl_wr & (busy | start)); // CTRL waits for the slice

	always_comb begin
		case (wb_adr)
			addr_a: rd_data = {{(32 - a_width){1'b0}}, a};
			addr_b: rd_data = {{(32 - b_width){1'b0}}, b};
			addr_c_lo: rd_data = c[31:0];
			addr_c_hi: rd_data = {{(64 - p_width){1'b0}}, c[p_width-1:32]};
			addr_ctrl: rd_data = {27'b0, cin, mode, opcode};
			addr_p_lo: rd_data = p[31:0];
			addr_p_hi: rd_data = {busy, 14'b0, cout, p[p_width-1:32]};
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			wb_dat_r <= '0;
			opcode <= op_mul_add;
			mode <= mode_27x18;
			cin <= 1'b0;
			a <= '0;
			b <= '0;
			c <= '0;
		end else begin
			wb_ack <= accept;
			start <= accept & ctrl_wr; // Lines up with the CTRL ack
			if (accept & ~wb_we)
				wb_dat_r <= rd_data;
			if (accept & wb_we) begin
				case (wb_adr)
					addr_a: a <= wb_dat_w[a_width-1:0];
					addr_b: b <= wb_dat_w[b_width-1:0];
					addr_c_lo: c[31:0] <= wb_dat_w;
					addr_c_hi: c[p_width-1:32] <= wb_dat_w[p_width-33:0];
					addr_ctrl: begin
						opcode <= opcode_e'(wb_dat_w[1:0]);
						mode <= simd_mode_e'(wb_dat_w[3:2]);
						cin <= wb_dat_w[4];
					end
					default: ;
				endcase
			end
		end
	end

	ack_single_pulse: assert property (@(posedge clk) disable iff (reset)
		(wb_ack && wb_cyc && wb_stb) |=> !wb_ack)
		else $error("wb_ack held for two cycles under one strobe");

endmodule
